/* logic/box_pkg.sv */
package box_pkg;

  localparam int MAX_SIZE       = 64;
  localparam int MIN_SIZE       = 9;
  localparam int WIN_LEN        = 8;
  localparam int PIX_W          = 8;
  localparam int SUM_W          = 11;
  localparam int ADDR_W         = 10;
  localparam int PIX_ADDR_W     = 12;
  localparam int STARTUP_CYCLES = 3;

  localparam int WORD_W  = 32;
  localparam int LANES   = WORD_W / PIX_W;
  localparam int CNT_W   = 10; // column counter width.
  localparam int SIZE_W  = 9;  // image width port.
  localparam int ROW_W   = 8;  // row counter, holds MAX_SIZE+1.
  localparam int SUM_MAX = WIN_LEN * 255;

  // controller state encodings.
  localparam logic [2:0] ST_IDLE       = 3'b000;
  localparam logic [2:0] ST_START      = 3'b001;
  localparam logic [2:0] ST_START_ROW  = 3'b010;
  localparam logic [2:0] ST_SUM_EN     = 3'b011;
  localparam logic [2:0] ST_CUM_EN     = 3'b100;
  localparam logic [2:0] ST_FINISH_ALL = 3'b101;

  // one buffer word, seen whole or as four byte lanes.
  typedef union packed {
    logic [WORD_W-1:0]            raw;
    logic [LANES-1:0][PIX_W-1:0]  pix; // pix[0] in bits 7:0.
  } pixel_word_u;

endpackage

/* logic/r4_controller.sv */
`timescale 1ns/1ns

module r4_controller
  import box_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  logic              start_gt_2_i,
  input  logic [CNT_W-1:0]  counter_i,
  input  logic [SIZE_W-1:0] img_size_i,
  input  logic              row_eq_max_i,
  output logic              cum_en_o,
  output logic              data_valid_o,
  output logic              sum_en_o,
  output logic              count_en_o,
  output logic              start_en_o,
  output logic              ld_en_o,
  output logic              finish_o,
  output logic              reset_en_o
);

  logic [2:0] state_q;
  logic [2:0] prev_state_q;
  logic [2:0] state_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      prev_state_q <= ST_IDLE;
    end else begin
      state_q      <= state_d;
      prev_state_q <= state_q; // marks the row's last sum.
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) state_d = ST_START;
      end
      ST_START: begin
        if (start_gt_2_i) state_d = ST_START_ROW;
      end
      ST_START_ROW: begin
        state_d = ST_SUM_EN;
      end
      ST_SUM_EN: begin
        if (row_eq_max_i) begin
          state_d = ST_FINISH_ALL;
        end else if (counter_i >= CNT_W'(WIN_LEN - 1)) begin
          state_d = ST_CUM_EN; // window filled.
        end
      end
      ST_CUM_EN: begin
        if (counter_i > {1'b0, img_size_i} - CNT_W'(2)) state_d = ST_START_ROW;
      end
      ST_FINISH_ALL: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_comb begin
    count_en_o   = 1'b0;
    data_valid_o = 1'b0;
    cum_en_o     = 1'b0;
    ld_en_o      = 1'b0;
    sum_en_o     = 1'b0;
    start_en_o   = 1'b0;
    finish_o     = 1'b0;
    reset_en_o   = 1'b0;
    case (state_q)
      ST_START: begin
        start_en_o = 1'b1;
      end
      ST_START_ROW: begin
        count_en_o = 1'b1;
        ld_en_o    = 1'b1;
        if (prev_state_q == ST_CUM_EN) data_valid_o = 1'b1; // last window of the row.
      end
      ST_SUM_EN: begin
        count_en_o = 1'b1;
        sum_en_o   = 1'b1;
      end
      ST_CUM_EN: begin
        count_en_o   = 1'b1;
        sum_en_o     = 1'b1;
        cum_en_o     = 1'b1;
        data_valid_o = 1'b1;
      end
      ST_FINISH_ALL: begin
        finish_o   = 1'b1;
        reset_en_o = 1'b1;
      end
      default: begin
        count_en_o = 1'b0;
      end
    endcase
  end

  a_no_valid_at_finish: assert property (@(posedge clk) disable iff (!rst_n)
    !(finish_o && data_valid_o));

  a_legal_state: assert property (@(posedge clk) disable iff (!rst_n)
    state_q <= ST_FINISH_ALL);

endmodule

/* logic/pixel_mem.sv */
`timescale 1ns/1ns

module pixel_mem
  import box_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [ADDR_W-1:0]     wb_adr_i,
  input  logic [WORD_W-1:0]     wb_dat_i,
  output logic [WORD_W-1:0]     wb_dat_o,
  output logic                  wb_ack_o,
  input  logic [PIX_ADDR_W-1:0] pix_addr_i,
  output logic [PIX_W-1:0]      pix_data_o
);

  localparam int MEM_WORDS = 1 << ADDR_W;

  pixel_word_u mem [MEM_WORDS];

  logic        req;
  pixel_word_u rd_word_q;
  pixel_word_u eng_word_q;
  logic [1:0]  lane_q;

  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o; // new cycle only.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req && wb_we_i) begin
      mem[wb_adr_i].raw <= wb_dat_i;
    end
    if (req) begin
      rd_word_q <= mem[wb_adr_i];
    end
  end

  assign wb_dat_o = rd_word_q.raw;

  // engine port, word then lane.
  always_ff @(posedge clk) begin
    eng_word_q <= mem[pix_addr_i[PIX_ADDR_W-1:2]];
    lane_q     <= pix_addr_i[1:0];
    pix_data_o <= eng_word_q.pix[lane_q];
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i));

endmodule

/* logic/row_address_gen.sv */
`timescale 1ns/1ns

module row_address_gen
  import box_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_en_i,
  input  logic                  ld_en_i,
  input  logic                  count_en_i,
  input  logic                  reset_en_i,
  input  logic [SIZE_W-1:0]     img_size_i,
  output logic [PIX_ADDR_W-1:0] pix_addr_o,
  output logic [CNT_W-1:0]      counter_o,
  output logic                  start_gt_2_o,
  output logic                  row_eq_max_o
);

  localparam int LIN_W = PIX_ADDR_W + 2;

  logic [1:0]       start_cnt_q;
  logic [CNT_W-1:0] col_q;
  logic [ROW_W-1:0] row_q; // rows loaded so far.
  logic             wrap;
  logic [LIN_W-1:0] lin_addr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_cnt_q <= '0;
    end else if (start_en_i) begin
      start_cnt_q <= start_cnt_q + 2'd1;
    end else begin
      start_cnt_q <= '0;
    end
  end

  assign start_gt_2_o = start_cnt_q >= 2'(STARTUP_CYCLES - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
    end else if (ld_en_i) begin
      col_q <= '0;
    end else if (start_en_i) begin
      // park at the row end so the fetch leads the first row.
      col_q <= start_gt_2_o ? CNT_W'(img_size_i) : CNT_W'(img_size_i) - CNT_W'(1);
    end else if (count_en_i) begin
      col_q <= col_q + CNT_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || reset_en_i || start_en_i) begin
      row_q <= '0;
    end else if (ld_en_i) begin
      row_q <= row_q + ROW_W'(1);
    end
  end

  assign row_eq_max_o = row_q == ROW_W'(img_size_i) + ROW_W'(1);
  assign counter_o    = col_q;

  // two pixels ahead, minus the row-load bubble.
  assign wrap     = col_q >= CNT_W'(img_size_i) - CNT_W'(1);
  assign lin_addr = LIN_W'(row_q) * LIN_W'(img_size_i) + LIN_W'(col_q) + LIN_W'(2)
                  - LIN_W'(wrap) - LIN_W'(img_size_i);
  assign pix_addr_o = lin_addr[PIX_ADDR_W-1:0];

  a_size_range: assert property (@(posedge clk) disable iff (!rst_n)
    start_en_i |-> (img_size_i >= SIZE_W'(MIN_SIZE) && img_size_i <= SIZE_W'(MAX_SIZE)));

endmodule

/* logic/window_sum.sv */
`timescale 1ns/1ns

module window_sum
  import box_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic [PIX_W-1:0] pix_i,
  input  logic             sum_en_i,
  input  logic             cum_en_i,
  input  logic             ld_en_i,
  output logic [SUM_W-1:0] sum_o
);

  logic [PIX_W-1:0] line_q [WIN_LEN]; // [0] is newest.
  logic [SUM_W-1:0] acc_q;
  logic [SUM_W-1:0] leaving;

  assign leaving = cum_en_i ? SUM_W'(line_q[WIN_LEN-1]) : '0;

  always_ff @(posedge clk) begin
    if (ld_en_i) begin
      for (int i = 0; i < WIN_LEN; i++) begin
        line_q[i] <= '0;
      end
    end else if (sum_en_i) begin
      line_q[0] <= pix_i;
      for (int i = 1; i < WIN_LEN; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (ld_en_i) begin
      acc_q <= '0;
    end else if (sum_en_i) begin
      acc_q <= acc_q + SUM_W'(pix_i) - leaving; // wraps back in range.
    end
  end

  assign sum_o = acc_q;

  a_sum_bound: assert property (@(posedge clk) disable iff (!rst_n)
    acc_q <= SUM_W'(SUM_MAX));

endmodule

/* logic/box_filter_top.sv */
`timescale 1ns/1ns

module box_filter_top
  import box_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [WORD_W-1:0] wb_dat_i,
  output logic [WORD_W-1:0] wb_dat_o,
  output logic              wb_ack_o,
  input  logic [SIZE_W-1:0] img_size_i,
  input  logic              start_i,
  output logic [SUM_W-1:0]  sum_o,
  output logic              valid_o,
  output logic              finish_o
);

  logic [PIX_ADDR_W-1:0] pix_addr;
  logic [PIX_W-1:0]      pix_data;
  logic [CNT_W-1:0]      counter;
  logic                  start_gt_2;
  logic                  row_eq_max;
  logic                  cum_en;
  logic                  sum_en;
  logic                  count_en;
  logic                  start_en;
  logic                  ld_en;
  logic                  reset_en;

  pixel_mem pixel_mem_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .pix_addr_i (pix_addr),
    .pix_data_o (pix_data)
  );

  row_address_gen row_address_gen_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_en_i   (start_en),
    .ld_en_i      (ld_en),
    .count_en_i   (count_en),
    .reset_en_i   (reset_en),
    .img_size_i   (img_size_i),
    .pix_addr_o   (pix_addr),
    .counter_o    (counter),
    .start_gt_2_o (start_gt_2),
    .row_eq_max_o (row_eq_max)
  );

  r4_controller r4_controller_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .start_gt_2_i (start_gt_2),
    .counter_i    (counter),
    .img_size_i   (img_size_i),
    .row_eq_max_i (row_eq_max),
    .cum_en_o     (cum_en),
    .data_valid_o (valid_o),
    .sum_en_o     (sum_en),
    .count_en_o   (count_en),
    .start_en_o   (start_en),
    .ld_en_o      (ld_en),
    .finish_o     (finish_o),
    .reset_en_o   (reset_en)
  );

  window_sum window_sum_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_i    (pix_data),
    .sum_en_i (sum_en),
    .cum_en_i (cum_en),
    .ld_en_i  (ld_en),
    .sum_o    (sum_o)
  );

endmodule

/* bench/box_filter_tb.sv */
`timescale 1ns/1ns

module box_filter_tb
  import box_pkg::*;
();

  logic              clk;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [WORD_W-1:0] wb_dat_w;
  logic [WORD_W-1:0] wb_dat_r;
  logic              wb_ack;
  logic [SIZE_W-1:0] img_size;
  logic              start;
  logic [SUM_W-1:0]  sum;
  logic              valid;
  logic              finish;

  logic [PIX_W-1:0] img [MAX_SIZE*MAX_SIZE]; // row-major pixels.
  int test_widths [5] = '{9, 64, 20, 33, 12};
  int cur_width;
  int exp_row;
  int exp_col;
  int sums_seen;
  int finish_cnt;
  bit run_active;
  int check_cnt;
  int err_cnt;
  int test_cnt;
  int test_checks0;
  int test_errs0;

  box_filter_top box_filter_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .img_size_i (img_size),
    .start_i    (start),
    .sum_o      (sum),
    .valid_o    (valid),
    .finish_o   (finish)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int watch_cycles();
    int total;
    total = 4000; // reset, read-back and gaps.
    foreach (test_widths[i]) begin
      total += 4 * test_widths[i] * test_widths[i];
    end
    return total;
  endfunction

  // sum of eight pixels starting at (row, col).
  function automatic logic [SUM_W-1:0] box_ref(input int row, input int col);
    int total;
    total = 0;
    for (int k = 0; k < WIN_LEN; k++) begin
      total += img[row*cur_width + col + k];
    end
    return SUM_W'(total);
  endfunction

  task automatic report_error(input string msg);
    err_cnt++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic check_sum(input logic [SUM_W-1:0] got, input logic [SUM_W-1:0] exp,
                           input int row, input int col);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t ns: sum at row %0d col %0d is %0d, expected %0d",
               $time, row, col, got, exp);
    end
  endtask

  task automatic check_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                            input logic [ADDR_W-1:0] adr);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t ns: word at address %0d reads %h, expected %h",
               $time, adr, got, exp);
    end
  endtask

  // one classic cycle, ack expected one clock after the strobe.
  task automatic wb_access(input logic we, input logic [ADDR_W-1:0] adr,
                           input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata);
    int waited;
    waited = 0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 16);
    check_cnt++;
    if (!wb_ack) begin
      report_error($sformatf("no ack for the bus cycle at address %0d", adr));
    end else if (waited != 1) begin
      report_error($sformatf("ack at address %0d came after %0d cycles", adr, waited));
    end
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    if (wb_ack) begin
      report_error($sformatf("second ack for the bus cycle at address %0d", adr));
    end
  endtask

  task automatic fill_image(input int width, input bit saturate);
    for (int p = 0; p < width*width; p++) begin
      img[p] = saturate ? 8'hff : PIX_W'($urandom);
    end
  endtask

  task automatic load_image(input int width);
    pixel_word_u       word;
    logic [WORD_W-1:0] unused;
    int                n_words;
    n_words = (width*width + LANES - 1) / LANES;
    for (int i = 0; i < n_words; i++) begin
      for (int l = 0; l < LANES; l++) begin
        word.pix[l] = (i*LANES + l < width*width) ? img[i*LANES + l] : '0;
      end
      wb_access(1'b1, ADDR_W'(i), word.raw, unused);
    end
  endtask

  task automatic run_image(input int width);
    int finish_before;
    int waited;
    @(negedge clk);
    img_size      = SIZE_W'(width);
    cur_width     = width;
    exp_row       = 0;
    exp_col       = 0;
    sums_seen     = 0;
    run_active    = 1'b1;
    finish_before = finish_cnt;
    start         = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    waited = 0;
    while (finish_cnt == finish_before && waited < 4*width*width) begin
      @(negedge clk);
      waited++;
    end
    if (finish_cnt == finish_before) begin
      report_error($sformatf("finish_o never came for the %0d-wide image", width));
      run_active = 1'b0;
    end else begin
      repeat (2*width) @(negedge clk); // quiet time, late sums show up here.
      check_cnt++;
      if (finish_cnt != finish_before + 1) begin
        report_error($sformatf("finish_o pulsed %0d times in one run",
                               finish_cnt - finish_before));
      end
    end
  endtask

  task automatic begin_test();
    test_checks0 = check_cnt;
    test_errs0   = err_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d checks, %0d errors", test_cnt, name,
             check_cnt - test_checks0, err_cnt - test_errs0);
  endtask

  // compares each valid sum in stream order.
  initial begin : compare_sums
    forever begin
      @(posedge clk);
      if (rst_n && valid) begin
        if (!run_active || exp_row >= cur_width) begin
          report_error("valid_o high with no sum expected");
        end else begin
          check_sum(sum, box_ref(exp_row, exp_col), exp_row, exp_col);
          sums_seen++;
          if (exp_col == cur_width - WIN_LEN) begin
            exp_col = 0;
            exp_row++;
          end else begin
            exp_col++;
          end
        end
      end
      if (rst_n && finish) begin
        finish_cnt++;
        if (!run_active) begin
          report_error("finish_o high outside a run");
        end else if (sums_seen != cur_width * (cur_width - WIN_LEN + 1)) begin
          report_error($sformatf("finish_o after %0d sums, %0d expected", sums_seen,
                                 cur_width * (cur_width - WIN_LEN + 1)));
        end
        run_active = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (watch_cycles()) @(posedge clk);
    $display("watchdog: the run did not end within %0d cycles, the DUT looks hung",
             watch_cycles());
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main_seq
    logic [WORD_W-1:0] words [32];
    logic [ADDR_W-1:0] addrs [32];
    logic [WORD_W-1:0] got;
    logic [ADDR_W-1:0] base;
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    img_size   = SIZE_W'(MIN_SIZE);
    start      = 1'b0;
    run_active = 1'b0;
    void'($urandom(32'h81816cc9));
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    begin_test();
    base = ADDR_W'($urandom);
    for (int i = 0; i < 32; i++) begin
      addrs[i] = base + ADDR_W'(i * 37); // spread over the buffer.
      words[i] = $urandom;
      wb_access(1'b1, addrs[i], words[i], got);
    end
    for (int i = 0; i < 32; i++) begin
      wb_access(1'b0, addrs[i], '0, got);
      check_word(got, words[i], addrs[i]);
    end
    end_test("buffer read-back");

    begin_test();
    fill_image(9, 1'b0);
    load_image(9);
    run_image(9);
    end_test("9x9 random image");

    begin_test();
    fill_image(64, 1'b0);
    load_image(64);
    run_image(64);
    end_test("64x64 random image");

    begin_test();
    fill_image(20, 1'b1);
    load_image(20);
    run_image(20);
    end_test("20x20 saturated image");

    begin_test();
    fill_image(33, 1'b0);
    load_image(33);
    run_image(33);
    fill_image(12, 1'b0);
    load_image(12);
    run_image(12);
    end_test("finish and restart");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
logic/box_pkg.sv
logic/r4_controller.sv
logic/pixel_mem.sv
logic/row_address_gen.sv
logic/window_sum.sv
logic/box_filter_top.sv
bench/box_filter_tb.sv

/* Bender.yml */
package:
  name: box_filter

sources:
  - files:
      - logic/box_pkg.sv
      - logic/r4_controller.sv
      - logic/pixel_mem.sv
      - logic/row_address_gen.sv
      - logic/window_sum.sv
      - logic/box_filter_top.sv
  - target: test
    files:
      - bench/box_filter_tb.sv
